/* source/fetchPkg.sv */
// ----------------------------------------------------------------------
// Shared widths, opcodes and select codes for the fetch and decode
// front end. Modules import it inside their body.
// ----------------------------------------------------------------------
package fetchPkg;

    localparam int instrWidth   = 16;
    localparam int addrWidth    = 8;    // 256 words
    localparam int opWidth      = 5;    // Instr bits 15 to 11
    localparam int regAddrWidth = 3;

    localparam logic [instrWidth-1:0] nopInstr = 16'h0800;

    localparam logic [opWidth-1:0] opHalt = 5'b00000;
    localparam logic [opWidth-1:0] opNop  = 5'b00001;
    localparam logic [opWidth-1:0] opJ    = 5'b00100;
    localparam logic [opWidth-1:0] opJr   = 5'b00101;
    localparam logic [opWidth-1:0] opJal  = 5'b00110;
    localparam logic [opWidth-1:0] opAddi = 5'b01000;
    localparam logic [opWidth-1:0] opBeqz = 5'b01100;
    localparam logic [opWidth-1:0] opSt   = 5'b10000;
    localparam logic [opWidth-1:0] opLd   = 5'b10001;
    localparam logic [opWidth-1:0] opAdd  = 5'b11011;

    // Immediate format for the execute stage
    localparam logic [2:0] immNone = 3'd0;
    localparam logic [2:0] immI5   = 3'd1;  // Sign extended bits 4 to 0
    localparam logic [2:0] immI8   = 3'd2;  // Sign extended bits 7 to 0
    localparam logic [2:0] immD11  = 3'd3;  // Jump displacement

    localparam logic [1:0] linkNone = 2'b00;
    localparam logic [1:0] linkPc   = 2'b01;  // Write back pc plus 2

    typedef enum logic [1:0] {
        destRs  = 2'b00,  // Bits 10 to 8
        destRdR = 2'b01,  // Bits 4 to 2
        destR7  = 2'b10,
        destRdI = 2'b11   // Bits 7 to 5
    } destSelT;

endpackage

/* source/pcRedirectIf.sv */
// ----------------------------------------------------------------------
// Signals that steer the next program counter. The decoder, hazard
// detector and top-level ports drive it and the program counter reads it.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

interface pcRedirectIf;
    import fetchPkg::*;

    logic                  stall;      // Load-use hold
    logic                  halt;
    logic                  regJump;    // Jump through rs
    logic                  takenSel;   // Taken branch from later stages
    logic [instrWidth-1:0] takenAddr;

    modport source (
        output stall, halt, regJump, takenSel, takenAddr
    );

    modport sink (
        input stall, halt, regJump, takenSel, takenAddr
    );

endinterface

/* source/progCounter.sv */
// ----------------------------------------------------------------------
// Program counter register. Picks the next fetch address from the
// redirect interface, in order halt, stall, taken branch, register jump.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module progCounter (
    input  logic                            clk,
    input  logic                            rstN,
    pcRedirectIf.sink                       redirect,
    input  logic [fetchPkg::instrWidth-1:0] rs,
    output logic [fetchPkg::instrWidth-1:0] pc
);
    import fetchPkg::*;

    logic [instrWidth-1:0] pcInc;
    logic [instrWidth-1:0] pcNext;
    logic                  holdPc;

    assign pcInc  = pc + instrWidth'(2);  // Byte address of next word
    assign holdPc = redirect.halt | redirect.stall;

    always_comb begin
        if (holdPc) begin
            pcNext = pc;
        end else if (redirect.takenSel) begin
            pcNext = redirect.takenAddr;
        end else if (redirect.regJump) begin
            pcNext = rs;
        end else begin
            pcNext = pcInc;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

endmodule

/* source/instrMem.sv */
// ----------------------------------------------------------------------
// Instruction memory of 256 words. Reads combinationally at the word
// address and is filled through the load port before the program runs.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module instrMem (
    input  logic                              clk,
    input  logic [fetchPkg::addrWidth-1:0]    addr,
    output logic [fetchPkg::instrWidth-1:0]   instr,
    input  logic                              loadEn,
    input  logic [fetchPkg::addrWidth-1:0]    loadAddr,
    input  logic [fetchPkg::instrWidth-1:0]   loadData
);
    import fetchPkg::*;

    localparam int depth = 2 ** addrWidth;

    logic [instrWidth-1:0] mem [depth];

    // Same cycle read
    assign instr = mem[addr];

    always_ff @(posedge clk) begin
        if (loadEn) begin
            mem[loadAddr] <= loadData;  // Visible after this edge
        end
    end

endmodule

/* source/instrDecode.sv */
// ----------------------------------------------------------------------
// Opcode decoder. Turns one instruction word into the control flags for
// the later stages and picks the destination register.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module instrDecode (
    input  logic [fetchPkg::instrWidth-1:0]   instr,
    output logic                              regWrite,
    output logic                              memEnable,
    output logic                              memWr,
    output logic                              val2Reg,
    output logic                              aluSel,
    output logic                              bFlag,
    output logic                              jFlag,
    output logic                              regJump,
    output logic                              halt,
    output logic                              ctrlErr,
    output logic                              readsRegs,
    output logic [2:0]                        immSel,
    output logic [1:0]                        linkReg,
    output logic [fetchPkg::regAddrWidth-1:0] writeRegAddr
);
    import fetchPkg::*;

    logic [opWidth-1:0] opcode;
    destSelT            destSel;

    assign opcode = instr[15:11];

    always_comb begin
        regWrite  = 1'b0;
        memEnable = 1'b0;
        memWr     = 1'b0;
        val2Reg   = 1'b0;
        aluSel    = 1'b0;      // Second operand from register
        bFlag     = 1'b0;
        jFlag     = 1'b0;
        regJump   = 1'b0;
        halt      = 1'b0;
        ctrlErr   = 1'b0;
        readsRegs = 1'b0;
        immSel    = immNone;
        linkReg   = linkNone;
        destSel   = destRs;
        case (opcode)
            opHalt: halt = 1'b1;
            opNop:  ;
            opLd: begin
                regWrite  = 1'b1;
                memEnable = 1'b1;
                val2Reg   = 1'b1;
                aluSel    = 1'b1;
                immSel    = immI5;
                destSel   = destRdI;
            end
            opSt: begin
                memEnable = 1'b1;
                memWr     = 1'b1;
                aluSel    = 1'b1;
                immSel    = immI5;
                readsRegs = 1'b1;
            end
            opAdd: begin
                regWrite  = 1'b1;
                readsRegs = 1'b1;
                destSel   = destRdR;
            end
            opAddi: begin
                regWrite  = 1'b1;
                aluSel    = 1'b1;
                immSel    = immI5;
                readsRegs = 1'b1;
                destSel   = destRdI;
            end
            opBeqz: begin
                bFlag     = 1'b1;
                immSel    = immI8;
                readsRegs = 1'b1;
            end
            opJ: begin
                jFlag  = 1'b1;
                immSel = immD11;
            end
            opJr: begin
                jFlag     = 1'b1;
                regJump   = 1'b1;
                immSel    = immI8;
                readsRegs = 1'b1;
            end
            opJal: begin
                jFlag    = 1'b1;
                regWrite = 1'b1;
                immSel   = immD11;
                linkReg  = linkPc;
                destSel  = destR7;
            end
            default: ctrlErr = 1'b1;  // Undefined opcode writes nothing
        endcase
    end

    always_comb begin
        case (destSel)
            destRdR: writeRegAddr = instr[4:2];
            destR7:  writeRegAddr = 3'b111;
            destRdI: writeRegAddr = instr[7:5];
            default: writeRegAddr = instr[10:8];
        endcase
    end

endmodule

/* source/hazardDetect.sv */
// ----------------------------------------------------------------------
// Load-use hazard check. Remembers whether the issued word was a load and
// raises nop and stall when the next raw word reads its destination.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module hazardDetect (
    input  logic                              clk,
    input  logic                              rstN,
    input  logic [fetchPkg::instrWidth-1:0]   rawInstr,
    input  logic                              rawReadsRegs,
    input  logic                              issuedLoad,
    input  logic [fetchPkg::regAddrWidth-1:0] issuedDest,
    output logic                              nop,
    pcRedirectIf.source                       redirect
);
    import fetchPkg::*;

    logic                    loadPending;
    logic [regAddrWidth-1:0] loadDest;
    logic [opWidth-1:0]      rawOp;
    logic                    usesSecond;
    logic                    firstMatch;
    logic                    secondMatch;

    assign rawOp = rawInstr[15:11];

    // Add and store also read bits 7 to 5
    assign usesSecond  = (rawOp == opAdd) || (rawOp == opSt);
    assign firstMatch  = rawInstr[10:8] == loadDest;
    assign secondMatch = usesSecond && (rawInstr[7:5] == loadDest);

    assign nop = loadPending && rawReadsRegs && (firstMatch || secondMatch);
    assign redirect.stall = nop;

    // A bubble never counts as a load so the repeated word goes through
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            loadPending <= 1'b0;
        end else begin
            loadPending <= issuedLoad & ~nop;
        end
    end

    always_ff @(posedge clk) begin
        loadDest <= issuedDest;
    end

endmodule

/* source/fetchStage.sv */
// ----------------------------------------------------------------------
// Fetch and decode front end. Ties the memory, program counter, hazard
// check and both decoders together and swaps in a bubble on a hazard.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module fetchStage (
    input  logic                              clk,
    input  logic                              rstN,
    input  logic                              loadEn,
    input  logic [fetchPkg::addrWidth-1:0]    loadAddr,
    input  logic [fetchPkg::instrWidth-1:0]   loadData,
    input  logic                              pcSel,
    input  logic [fetchPkg::instrWidth-1:0]   brnchAddr,
    input  logic [fetchPkg::instrWidth-1:0]   rs,
    output logic [fetchPkg::instrWidth-1:0]   pc,
    output logic [fetchPkg::instrWidth-1:0]   instrC,
    output logic [fetchPkg::regAddrWidth-1:0] writeRegAddr,
    output logic                              regWrite,
    output logic                              memEnable,
    output logic                              memWr,
    output logic                              val2Reg,
    output logic                              aluSel,
    output logic [2:0]                        immSel,
    output logic [1:0]                        linkReg,
    output logic                              bFlag,
    output logic                              jFlag,
    output logic                              regJump,
    output logic                              halt,
    output logic                              ctrlErr
);
    import fetchPkg::*;

    logic [instrWidth-1:0] rawInstr;
    logic                  nop;
    logic                  rawReadsRegs;

    pcRedirectIf redirect ();

    assign redirect.takenSel  = pcSel;
    assign redirect.takenAddr = brnchAddr;
    assign redirect.halt      = halt;
    assign redirect.regJump   = regJump;

    instrMem imem (
        .clk      (clk),
        .addr     (pc[addrWidth:1]),  // Word address
        .instr    (rawInstr),
        .loadEn   (loadEn),
        .loadAddr (loadAddr),
        .loadData (loadData)
    );

    progCounter pcReg (
        .clk      (clk),
        .rstN     (rstN),
        .redirect (redirect.sink),
        .rs       (rs),
        .pc       (pc)
    );

    assign instrC = nop ? nopInstr : rawInstr;

    // Decodes the word sent down the pipeline
    instrDecode mainDecode (
        .instr        (instrC),
        .regWrite     (regWrite),
        .memEnable    (memEnable),
        .memWr        (memWr),
        .val2Reg      (val2Reg),
        .aluSel       (aluSel),
        .bFlag        (bFlag),
        .jFlag        (jFlag),
        .regJump      (regJump),
        .halt         (halt),
        .ctrlErr      (ctrlErr),
        .readsRegs    (),
        .immSel       (immSel),
        .linkReg      (linkReg),
        .writeRegAddr (writeRegAddr)
    );

    // Sees the raw word before any bubble
    instrDecode chkDecode (
        .instr        (rawInstr),
        .regWrite     (),
        .memEnable    (),
        .memWr        (),
        .val2Reg      (),
        .aluSel       (),
        .bFlag        (),
        .jFlag        (),
        .regJump      (),
        .halt         (),
        .ctrlErr      (),
        .readsRegs    (rawReadsRegs),
        .immSel       (),
        .linkReg      (),
        .writeRegAddr ()
    );

    hazardDetect hazard (
        .clk          (clk),
        .rstN         (rstN),
        .rawInstr     (rawInstr),
        .rawReadsRegs (rawReadsRegs),
        .issuedLoad   (val2Reg),  // Only a load sets val2Reg
        .issuedDest   (writeRegAddr),
        .nop          (nop),
        .redirect     (redirect.source)
    );

endmodule

/* test/clockGen.sv */
// ----------------------------------------------------------------------
// Testbench clock and reset. 100 ns period, reset held low for the
// first 8 rising edges and released on an edge.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module clockGen (
    output logic clk,
    output logic rstN
);
    localparam int resetCycles = 8;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        rstN <= 1'b1;
    end

endmodule

/* test/fetchChecker.sv */
// ----------------------------------------------------------------------
// Reference model of the fetch front end. Samples the DUT on the falling
// edge, compares every output and then steps its own state.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module fetchChecker (
    input  logic                              clk,
    input  logic                              rstN,
    input  logic                              loadEn,
    input  logic [fetchPkg::addrWidth-1:0]    loadAddr,
    input  logic [fetchPkg::instrWidth-1:0]   loadData,
    input  logic                              pcSel,
    input  logic [fetchPkg::instrWidth-1:0]   brnchAddr,
    input  logic [fetchPkg::instrWidth-1:0]   rs,
    input  logic [fetchPkg::instrWidth-1:0]   pc,
    input  logic [fetchPkg::instrWidth-1:0]   instrC,
    input  logic [fetchPkg::regAddrWidth-1:0] writeRegAddr,
    input  logic                              regWrite,
    input  logic                              memEnable,
    input  logic                              memWr,
    input  logic                              val2Reg,
    input  logic                              aluSel,
    input  logic [2:0]                        immSel,
    input  logic [1:0]                        linkReg,
    input  logic                              bFlag,
    input  logic                              jFlag,
    input  logic                              regJump,
    input  logic                              halt,
    input  logic                              ctrlErr,
    output int                                errors,
    output int                                checkedCycles
);
    import fetchPkg::*;

    logic [instrWidth-1:0]   modelMem [2**addrWidth];
    logic [instrWidth-1:0]   modelPc;
    logic                    prevLoad;   // Issued word last cycle was a load
    logic [regAddrWidth-1:0] prevDest;

    initial begin
        errors        = 0;
        checkedCycles = 0;
    end

    // Bits 14 to 5 are regWrite memEnable memWr val2Reg aluSel bFlag
    // jFlag regJump halt ctrlErr, then immSel and linkReg
    function automatic logic [14:0] expectFlags(input logic [opWidth-1:0] op);
        case (op)
            opHalt:  return {10'b0000000010, immNone, linkNone};
            opNop:   return {10'b0000000000, immNone, linkNone};
            opLd:    return {10'b1101100000, immI5, linkNone};
            opSt:    return {10'b0110100000, immI5, linkNone};
            opAdd:   return {10'b1000000000, immNone, linkNone};
            opAddi:  return {10'b1000100000, immI5, linkNone};
            opBeqz:  return {10'b0000010000, immI8, linkNone};
            opJ:     return {10'b0000001000, immD11, linkNone};
            opJr:    return {10'b0000001100, immI8, linkNone};
            opJal:   return {10'b1000001000, immD11, linkPc};
            default: return {10'b0000000001, immNone, linkNone};
        endcase
    endfunction

    function automatic logic [regAddrWidth-1:0] expectDest(input logic [instrWidth-1:0] w);
        if (w[15:11] == opAdd) begin
            return w[4:2];
        end else if (w[15:11] == opAddi || w[15:11] == opLd) begin
            return w[7:5];
        end else if (w[15:11] == opJal) begin
            return 3'd7;                        // Link register
        end
        return w[10:8];
    endfunction

    function automatic logic readsRegs(input logic [opWidth-1:0] op);
        return op == opAdd || op == opAddi || op == opSt || op == opBeqz || op == opJr;
    endfunction

    task automatic compare(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s at pc %h: got %h expected %h", name, modelPc, got, exp);
            errors++;
        end
    endtask

    always @(negedge clk) begin : step
        logic [instrWidth-1:0]   raw;
        logic [opWidth-1:0]      rawOp;
        logic                    hazard;
        logic [instrWidth-1:0]   expInstr;
        logic [14:0]             exp;
        logic [regAddrWidth-1:0] expDest;
        if (rstN) begin
            raw      = modelMem[modelPc[addrWidth:1]];
            rawOp    = raw[15:11];
            hazard   = prevLoad && readsRegs(rawOp) && (raw[10:8] == prevDest ||
                       ((rawOp == opAdd || rawOp == opSt) && raw[7:5] == prevDest));
            expInstr = hazard ? nopInstr : raw;
            exp      = expectFlags(expInstr[15:11]);
            expDest  = expectDest(expInstr);
            compare("pc", pc, modelPc);
            compare("instrC", instrC, expInstr);
            compare("writeRegAddr", writeRegAddr, expDest);
            compare("regWrite", regWrite, exp[14]);
            compare("memEnable", memEnable, exp[13]);
            compare("memWr", memWr, exp[12]);
            compare("val2Reg", val2Reg, exp[11]);
            compare("aluSel", aluSel, exp[10]);
            compare("bFlag", bFlag, exp[9]);
            compare("jFlag", jFlag, exp[8]);
            compare("regJump", regJump, exp[7]);
            compare("halt", halt, exp[6]);
            compare("ctrlErr", ctrlErr, exp[5]);
            compare("immSel", immSel, exp[4:2]);
            compare("linkReg", linkReg, exp[1:0]);
            checkedCycles++;
            prevLoad = expInstr[15:11] == opLd;  // A bubble is never a load
            prevDest = expDest;
            if (!(exp[6] || hazard)) begin
                if (pcSel) begin
                    modelPc = brnchAddr;
                end else if (exp[7]) begin
                    modelPc = rs;
                end else begin
                    modelPc = modelPc + 16'd2;
                end
            end
        end else begin
            modelPc  = '0;
            prevLoad = 1'b0;
        end
        // DUT writes on the next rising edge
        if (loadEn) begin
            modelMem[loadAddr] = loadData;
        end
    end

endmodule

/* test/fetchStage_sva.sv */
// ----------------------------------------------------------------------
// Concurrent assertions on the fetch front end, bound into fetchStage.
// Failures are counted so the testbench can read them at the end.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module fetchStageSva (
    input logic                            clk,
    input logic                            rstN,
    input logic                            nop,
    input logic                            halt,
    input logic [fetchPkg::instrWidth-1:0] pc
);
    int failures = 0;

    noBubbleOnHalt: assert property (@(posedge clk) disable iff (!rstN) !(nop && halt))
        else begin
            $error("nop and halt are high together");
            failures++;
        end

    // Repeated word must go through after one bubble
    bubbleOneCycle: assert property (@(posedge clk) disable iff (!rstN) nop |=> !nop)
        else begin
            $error("nop stayed high for more than one cycle");
            failures++;
        end

    pcAligned: assert property (@(posedge clk) disable iff (!rstN) !pc[0])
        else begin
            $error("pc is odd: %h", pc);
            failures++;
        end

endmodule

bind fetchStage fetchStageSva assertions (
    .clk  (clk),
    .rstN (rstN),
    .nop  (nop),
    .halt (halt),
    .pc   (pc)
);

/* test/fetchTb.sv */
// ----------------------------------------------------------------------
// Testbench top for the fetch front end. Loads the program table and a
// halt pad, then walks the segments by clearing each halt and redirecting.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module fetchTb;
    import fetchPkg::*;

    typedef struct packed {
        logic [addrWidth-1:0]  addr;     // Word address
        logic [instrWidth-1:0] word;
        logic [7:0]            hold;     // Halt cycles before restart, 0 on plain rows
        logic [instrWidth-1:0] nextPc;
    } rowT;

    localparam int numRows       = 19;
    localparam int timeoutCycles = 200;
    localparam int padBase       = 128;  // Words 128 to 255 hold halts
    localparam logic [instrWidth-1:0] endOfRun = 16'hFFFF;

    localparam rowT progTable [numRows] = '{
        '{8'd0,  {opHalt, 11'h000}, 8'd2, 16'h0002},       // Parked until start
        '{8'd1,  nopInstr, 8'd0, 16'h0000},
        '{8'd2,  {opAddi, 3'd2, 3'd6, 5'd5}, 8'd0, 16'h0000},
        '{8'd3,  {opBeqz, 3'd5, 8'h03}, 8'd0, 16'h0000},
        '{8'd4,  {opJ, 11'h004}, 8'd0, 16'h0000},
        '{8'd5,  {opJal, 11'h010}, 8'd0, 16'h0000},
        '{8'd6,  {5'b11111, 11'h0A5}, 8'd0, 16'h0000},     // Undefined opcode
        '{8'd7,  {opLd, 3'd1, 3'd3, 5'd0}, 8'd0, 16'h0000},
        '{8'd8,  {opAdd, 3'd3, 3'd2, 3'd4, 2'b00}, 8'd0, 16'h0000},  // Uses r3
        '{8'd9,  {opLd, 3'd1, 3'd3, 5'd0}, 8'd0, 16'h0000},
        '{8'd10, {opAdd, 3'd1, 3'd2, 3'd5, 2'b00}, 8'd0, 16'h0000},  // Independent
        '{8'd11, {opLd, 3'd1, 3'd3, 5'd0}, 8'd0, 16'h0000},
        '{8'd12, {opSt, 3'd2, 3'd3, 5'd0}, 8'd0, 16'h0000},  // r3 in bits 7 to 5
        '{8'd13, {opHalt, 11'h00D}, 8'd3, 16'h0028},
        '{8'd20, {opLd, 3'd1, 3'd3, 5'd0}, 8'd0, 16'h0000},
        '{8'd21, {opJr, 3'd3, 8'h00}, 8'd2, 16'h003C},      // Ends in the halt pad
        '{8'd30, {opAddi, 3'd2, 3'd6, 5'd5}, 8'd0, 16'h0000},
        '{8'd31, {opAdd, 3'd1, 3'd2, 3'd5, 2'b00}, 8'd0, 16'h0000},
        '{8'd32, {opHalt, 11'h020}, 8'd20, endOfRun}
    };

    logic                    clk;
    logic                    rstN;
    logic                    loadEn;
    logic [addrWidth-1:0]    loadAddr;
    logic [instrWidth-1:0]   loadData;
    logic                    pcSel;
    logic [instrWidth-1:0]   brnchAddr;
    logic [instrWidth-1:0]   rs;
    logic [instrWidth-1:0]   pc;
    logic [instrWidth-1:0]   instrC;
    logic [regAddrWidth-1:0] writeRegAddr;
    logic                    regWrite;
    logic                    memEnable;
    logic                    memWr;
    logic                    val2Reg;
    logic                    aluSel;
    logic [2:0]              immSel;
    logic [1:0]              linkReg;
    logic                    bFlag;
    logic                    jFlag;
    logic                    regJump;
    logic                    halt;
    logic                    ctrlErr;
    int                      errors;
    int                      checkedCycles;
    int                      timeouts;
    logic [31:0]             rngState;

    clockGen clkGen (.clk(clk), .rstN(rstN));

    fetchStage fetchStage_inst (.*);

    fetchChecker monitor (.*);

    function automatic logic [31:0] nextRandom(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // Fresh jump target every cycle, taken only by opJr
    always @(posedge clk) begin
        rngState <= nextRandom(rngState);
        rs       <= {rngState[15:9], 1'b1, rngState[7:1], 1'b0};  // Even, inside the pad
    end

    task automatic loadWord(input logic [addrWidth-1:0] addr, input logic [instrWidth-1:0] word);
        @(posedge clk);
        loadEn   <= 1'b1;
        loadAddr <= addr;
        loadData <= word;
    endtask

    task automatic waitForHalt(output bit seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < timeoutCycles) begin
            @(negedge clk);
            seen = halt === 1'b1;
            cycles++;
        end
        if (!seen) begin
            $display("Timeout: halt was not reached within %0d cycles", timeoutCycles);
            timeouts++;
        end
    endtask

    // Replace the halt word with a nop, then redirect once it is gone
    task automatic restartAt(input logic [instrWidth-1:0] haltAt, input logic [instrWidth-1:0] target);
        @(posedge clk);
        loadEn   <= 1'b1;
        loadAddr <= haltAt[addrWidth:1];
        loadData <= nopInstr;
        @(posedge clk);
        loadEn    <= 1'b0;
        pcSel     <= 1'b1;
        brnchAddr <= target;
        @(posedge clk);
        pcSel <= 1'b0;
    endtask

    initial begin
        bit ok;
        int i;
        loadEn    = 1'b0;
        loadAddr  = '0;
        loadData  = '0;
        pcSel     = 1'b0;
        brnchAddr = '0;
        rs        = '0;
        rngState  = 32'h602b_f4c0;
        timeouts  = 0;
        // Word 0 goes in first, during reset, so pc parks on a halt
        for (i = 0; i < numRows; i++) begin
            loadWord(progTable[i].addr, progTable[i].word);
        end
        for (int a = padBase; a < 2**addrWidth; a++) begin
            loadWord(a[addrWidth-1:0], {opHalt, 3'b000, a[7:0]});
        end
        @(posedge clk);
        loadEn <= 1'b0;
        ok = 1'b1;
        for (i = 0; i < numRows && ok; i++) begin
            if (progTable[i].hold != 0) begin
                waitForHalt(ok);
                if (ok) begin
                    repeat (progTable[i].hold) @(negedge clk);
                    if (progTable[i].nextPc != endOfRun) begin
                        restartAt(pc, progTable[i].nextPc);
                    end
                end
            end
        end
        @(negedge clk);
        $display("Summary: %0d mismatches, %0d timeouts, %0d assertion failures, %0d cycles checked",
                 errors, timeouts, fetchStage_inst.assertions.failures, checkedCycles);
        if (errors == 0 && timeouts == 0 && fetchStage_inst.assertions.failures == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* filelist.f */
source/fetchPkg.sv
source/pcRedirectIf.sv
source/progCounter.sv
source/instrMem.sv
source/instrDecode.sv
source/hazardDetect.sv
source/fetchStage.sv
test/clockGen.sv
test/fetchChecker.sv
test/fetchStage_sva.sv
test/fetchTb.sv
